/* logic/sdram_refresh_pkg.sv */
/*
 * Shared definitions for the SDRAM refresh path:
 * command and FSM state enums, timing constants, pin bundle struct
 */
`default_nettype none

package sdram_refresh_pkg;

  // SDRAM timing, counted in controller clocks
  localparam int unsigned T_RP = 2;              // NOPs after PRECHARGE ALL
  localparam int unsigned T_RC = 9;              // NOPs after AUTO REFRESH

  // Shortened tREFI so simulation stays fast
  localparam int unsigned REFRESH_INTERVAL = 64;
  localparam int unsigned REFRESH_TIMER_W  = $clog2(REFRESH_INTERVAL);

  // Owed refresh bookkeeping
  localparam int unsigned BACKLOG_MAX = 8;
  localparam int unsigned BACKLOG_W   = 4;       // Must hold BACKLOG_MAX

  // NOP wait counter, sized for the longer wait
  localparam int unsigned NOP_CNT_W = $clog2(T_RC + 1);

  // Address pin layout
  localparam int unsigned ADDR_W       = 13;
  localparam int unsigned BA_W         = 2;
  localparam int unsigned ADDR_A10_BIT = 10;     // All banks select

  // Command code, bit order {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP       = 4'b0111,
    CMD_PRECHARGE = 4'b0010,
    CMD_REFRESH   = 4'b0001
  } sdram_cmd_e;

  // Refresh FSM states
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,  // Waiting for owed refresh and idle host
    ST_PALL     = 3'd1,  // PRECHARGE ALL issued
    ST_PALL_NOP = 3'd2,  // tRP wait
    ST_REF      = 3'd3,  // AUTO REFRESH issued
    ST_REF_NOP  = 3'd4   // tRC wait, done on last cycle
  } refresh_state_e;

  // SDRAM control pins, 19 bits
  typedef struct packed {
    sdram_cmd_e        cmd;
    logic [BA_W-1:0]   ba;
    logic [ADDR_W-1:0] addr;
  } sdram_bus_t;

endpackage

`default_nettype wire

/* logic/refresh_timer.sv */
/*
 * Refresh interval timer
 * One-cycle tick every REFRESH_INTERVAL clocks
 */
`timescale 1ns/1ps
`default_nettype none

module refresh_timer (
  input  logic clock,
  input  logic reset,
  output logic tick   // Refresh request pulse
);

  localparam int unsigned CNT_W = sdram_refresh_pkg::REFRESH_TIMER_W;

  // Reload value gives exactly REFRESH_INTERVAL cycles per period
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(sdram_refresh_pkg::REFRESH_INTERVAL - 1);

  logic [CNT_W-1:0] count;  // Cycles left in current period

  // Free-running down counter, starts on reset release
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      count <= RELOAD;
    end else if (count == '0) begin
      count <= RELOAD;  // Wrap, next period begins
    end else begin
      count <= count - 1'b1;
    end
  end

  // Terminal count marks the request
  assign tick = (count == '0);

endmodule

`default_nettype wire

/* logic/refresh_backlog.sv */
/*
 * Owed refresh counter
 * Saturates at BACKLOG_MAX, sticky overflow on a lost tick
 */
`timescale 1ns/1ps
`default_nettype none

module refresh_backlog (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   tick,      // New refresh owed
  input  logic                                   done,      // One refresh completed
  output logic                                   pending,   // Count not zero
  output logic [sdram_refresh_pkg::BACKLOG_W-1:0] count,
  output logic                                   overflow   // Refresh lost, until reset
);

  localparam int unsigned CNT_W = sdram_refresh_pkg::BACKLOG_W;
  localparam logic [CNT_W-1:0] FULL = CNT_W'(sdram_refresh_pkg::BACKLOG_MAX);

  logic [CNT_W-1:0] count_next;
  logic             lost;  // Tick arriving with no room

  always_comb begin
    count_next = count;
    lost       = 1'b0;
    if (tick && !done) begin
      if (count == FULL) begin
        lost = 1'b1;  // Saturated, tick dropped
      end else begin
        count_next = count + 1'b1;
      end
    end else if (done && !tick) begin
      if (count != '0) count_next = count - 1'b1;  // Guard against underflow
    end
    // Tick and done together cancel out
  end

  // Count and pending move together so the FSM needs no compare
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      count    <= '0;
      pending  <= 1'b0;
      overflow <= 1'b0;
    end else begin
      count    <= count_next;
      pending  <= (count_next != '0);
      if (lost) overflow <= 1'b1;  // Sticky
    end
  end

endmodule

`default_nettype wire

/* logic/refresh_sequencer.sv */
/*
 * Refresh FSM
 * PRECHARGE ALL, tRP NOPs, AUTO REFRESH, tRC NOPs, done pulse
 */
`timescale 1ns/1ps
`default_nettype none

module refresh_sequencer (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          pending,    // Refresh owed
  input  logic                          host_idle,  // Host off the bus
  output logic                          busy,       // High outside idle
  output logic                          done,       // Last tRC cycle
  output sdram_refresh_pkg::sdram_bus_t sdram
);

  localparam int unsigned CNT_W = sdram_refresh_pkg::NOP_CNT_W;
  localparam logic [CNT_W-1:0] RP_END = CNT_W'(sdram_refresh_pkg::T_RP);
  localparam logic [CNT_W-1:0] RC_END = CNT_W'(sdram_refresh_pkg::T_RC);

  // Only A10 driven, selects all banks
  localparam logic [sdram_refresh_pkg::ADDR_W-1:0] ADDR_ALL_BANKS =
    sdram_refresh_pkg::ADDR_W'(1) << sdram_refresh_pkg::ADDR_A10_BIT;

  sdram_refresh_pkg::refresh_state_e state, state_next;

  logic [CNT_W-1:0] nop_cnt;    // NOP cycles elapsed in a wait
  logic             nop_clear;  // Zero the counter this cycle
  logic             rp_end;
  logic             rc_end;

  assign rp_end = (nop_cnt == RP_END);
  assign rc_end = (nop_cnt == RC_END);

  // State register
  always_ff @(posedge clock or posedge reset) begin
    if (reset) state <= sdram_refresh_pkg::ST_IDLE;
    else       state <= state_next;
  end

  // Wait counter, runs only in the NOP states
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      nop_cnt <= '0;
    end else if (nop_clear) begin
      nop_cnt <= '0;
    end else begin
      nop_cnt <= nop_cnt + 1'b1;
    end
  end

  // Next state and command decode
  always_comb begin
    state_next = state;
    nop_clear  = 1'b0;
    done       = 1'b0;
    sdram.cmd  = sdram_refresh_pkg::CMD_NOP;  // Default command
    sdram.ba   = '0;
    sdram.addr = ADDR_ALL_BANKS;
    case (state)
      sdram_refresh_pkg::ST_IDLE: begin
        nop_clear = 1'b1;
        // Start only when owed and the host has let go
        if (pending && host_idle) state_next = sdram_refresh_pkg::ST_PALL;
      end
      sdram_refresh_pkg::ST_PALL: begin
        sdram.cmd  = sdram_refresh_pkg::CMD_PRECHARGE;
        nop_clear  = 1'b1;
        state_next = sdram_refresh_pkg::ST_PALL_NOP;
      end
      sdram_refresh_pkg::ST_PALL_NOP: begin
        if (rp_end) state_next = sdram_refresh_pkg::ST_REF;  // T_RP+1 cycles
      end
      sdram_refresh_pkg::ST_REF: begin
        sdram.cmd  = sdram_refresh_pkg::CMD_REFRESH;
        nop_clear  = 1'b1;
        state_next = sdram_refresh_pkg::ST_REF_NOP;
      end
      sdram_refresh_pkg::ST_REF_NOP: begin
        if (rc_end) begin
          done       = 1'b1;  // Backlog drops one on this edge
          state_next = sdram_refresh_pkg::ST_IDLE;
        end
      end
      default: begin
        nop_clear  = 1'b1;
        state_next = sdram_refresh_pkg::ST_IDLE;  // Recover from bad encoding
      end
    endcase
  end

  // No abort path, host watches busy
  assign busy = (state != sdram_refresh_pkg::ST_IDLE);

endmodule

`default_nettype wire

/* logic/sdram_refresh_top.sv */
/*
 * SDRAM refresh path top level
 * Timer feeds backlog, backlog feeds FSM, FSM drives the pins
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_refresh_top (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    host_idle,         // Host not using SDRAM
  output sdram_refresh_pkg::sdram_bus_t           sdram,
  output logic                                    refresh_busy,
  output logic                                    refresh_done,      // One-cycle pulse
  output logic [sdram_refresh_pkg::BACKLOG_W-1:0] backlog_count,
  output logic                                    backlog_overflow   // Sticky
);

  logic tick;     // Timer to backlog
  logic pending;  // Backlog to FSM

  // Refresh period source
  refresh_timer u_timer (
    .clock (clock),
    .reset (reset),
    .tick  (tick)
  );

  // Owed refreshes, done pulse pays one back
  refresh_backlog u_backlog (
    .clock    (clock),
    .reset    (reset),
    .tick     (tick),
    .done     (refresh_done),
    .pending  (pending),
    .count    (backlog_count),
    .overflow (backlog_overflow)
  );

  // Command sequencing on the SDRAM pins
  refresh_sequencer u_sequencer (
    .clock     (clock),
    .reset     (reset),
    .pending   (pending),
    .host_idle (host_idle),
    .busy      (refresh_busy),
    .done      (refresh_done),
    .sdram     (sdram)
  );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
/*
 * Testbench clock and reset source
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 8
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  // Release just after an edge, same as the other stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire

/* bench/tb_sdram_refresh.sv */
/*
 * Refresh path testbench
 * Seeded random host_idle, cycle model, typed compare tasks, watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_refresh;

  localparam int CLK_PERIOD_NS = 8;
  localparam int SEED          = 32'h5ec6_8e3b;
  localparam int INTERVAL      = sdram_refresh_pkg::REFRESH_INTERVAL;
  localparam int MAX_OWED      = sdram_refresh_pkg::BACKLOG_MAX;
  localparam int REF_AT        = sdram_refresh_pkg::T_RP + 2;  // PRECHARGE to REFRESH
  localparam int SEQ_LEN       = sdram_refresh_pkg::T_RP + sdram_refresh_pkg::T_RC + 4;
  localparam int DRAIN_LEN     = 2 * (MAX_OWED + 1) * SEQ_LEN;
  localparam int RANDOM_CYCLES = 4000;
  // Worst-case lengths of tests 1 to 6, in cycles
  localparam int RUN_CYCLES = INTERVAL + (2 * INTERVAL + 4 * SEQ_LEN)
    + (MAX_OWED - 1) * INTERVAL + DRAIN_LEN + ((MAX_OWED + 2) * INTERVAL + DRAIN_LEN)
    + (RANDOM_CYCLES + 3 * INTERVAL + DRAIN_LEN);
  localparam int MARGIN_CYCLES = 200;

  // What run_until waits for
  localparam int EV_OWED    = 0;
  localparam int EV_PALL    = 1;
  localparam int EV_REF     = 2;
  localparam int EV_DONE    = 3;
  localparam int EV_IDLE    = 4;
  localparam int EV_DRAINED = 5;

  logic clock;
  logic reset;
  logic host_idle;
  sdram_refresh_pkg::sdram_bus_t sdram;
  logic refresh_busy;
  logic refresh_done;
  logic [sdram_refresh_pkg::BACKLOG_W-1:0] backlog_count;
  logic backlog_overflow;

  // Model state, all values of the current cycle
  int   cyc;          // Cycle number, 1 is the first after reset release
  bit   m_active;     // Sequence running
  int   m_phase;      // Cycles since PRECHARGE
  logic [sdram_refresh_pkg::BACKLOG_W-1:0] m_count;
  bit   m_overflow;
  logic m_idle;       // Level the DUT samples at the next edge
  int   m_ticks;      // Ticks already counted in
  int   m_lost;       // Ticks dropped when full
  int   m_done;       // Sequences the model has completed
  int   pall_seen;
  int   ref_seen;
  int   done_seen;
  int   errors;
  int   test_errors_at;
  int   tests_passed;
  int   tests_failed;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(8)) u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  sdram_refresh_top UUT (
    .clock            (clock),
    .reset            (reset),
    .host_idle        (host_idle),
    .sdram            (sdram),
    .refresh_busy     (refresh_busy),
    .refresh_done     (refresh_done),
    .backlog_count    (backlog_count),
    .backlog_overflow (backlog_overflow)
  );

  task automatic check_bus(input string name, input sdram_refresh_pkg::sdram_bus_t expected,
                           input sdram_refresh_pkg::sdram_bus_t actual);
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s cycle %0d: expected %h, got %h", name, cyc, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s cycle %0d: expected %h, got %h", name, cyc, expected, actual);
    end
  endtask

  task automatic check_count(input string name,
                             input logic [sdram_refresh_pkg::BACKLOG_W-1:0] expected,
                             input logic [sdram_refresh_pkg::BACKLOG_W-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s cycle %0d: expected %h, got %h", name, cyc, expected, actual);
    end
  endtask

  task automatic expect_number(input string what, input int expected, input int actual);
    if (actual != expected) begin
      errors++;
      $display("%s was %0d but should be %0d", what, actual, expected);
    end
  endtask

  // NOP, bank zero, A10 high
  function automatic sdram_refresh_pkg::sdram_bus_t idle_bus();
    sdram_refresh_pkg::sdram_bus_t b;
    b.cmd  = sdram_refresh_pkg::CMD_NOP;
    b.ba   = '0;
    b.addr = '0;
    b.addr[sdram_refresh_pkg::ADDR_A10_BIT] = 1'b1;
    return b;
  endfunction

  // Clock edge of the model, uses this cycle's values only
  task automatic advance_model();
    bit tick_now;
    bit done_now;
    tick_now = (cyc % INTERVAL) == 0;  // Tick every interval, first in cycle INTERVAL
    done_now = m_active && (m_phase == SEQ_LEN - 1);
    if (m_active) begin
      if (done_now) m_active = 1'b0;
      else m_phase++;
    end else if (m_count != 0 && m_idle) begin
      m_active = 1'b1;  // PRECHARGE next cycle
      m_phase  = 0;
    end
    if (tick_now && !done_now) begin
      if (m_count == MAX_OWED) begin
        m_overflow = 1'b1;
        m_lost++;
      end else begin
        m_count++;
      end
    end else if (done_now && !tick_now && m_count != 0) begin
      m_count--;
    end
    if (tick_now) m_ticks++;
    if (done_now) m_done++;
    cyc++;
  endtask

  task automatic compare_outputs();
    sdram_refresh_pkg::sdram_bus_t exp_bus;
    exp_bus = idle_bus();
    if (m_active && m_phase == 0) exp_bus.cmd = sdram_refresh_pkg::CMD_PRECHARGE;
    else if (m_active && m_phase == REF_AT) exp_bus.cmd = sdram_refresh_pkg::CMD_REFRESH;
    check_bus("sdram", exp_bus, sdram);
    check_flag("refresh_busy", m_active, refresh_busy);
    check_flag("refresh_done", m_active && m_phase == SEQ_LEN - 1, refresh_done);
    check_count("backlog_count", m_count, backlog_count);
    check_flag("backlog_overflow", m_overflow, backlog_overflow);
    if (sdram.cmd == sdram_refresh_pkg::CMD_PRECHARGE) pall_seen++;
    if (sdram.cmd == sdram_refresh_pkg::CMD_REFRESH) ref_seen++;
    if (refresh_done) done_seen++;
  endtask

  // One cycle: edge, drive 1 ns later, sample mid-cycle
  task automatic run_cycle(input logic idle_value);
    @(posedge clock);
    advance_model();
    #1 host_idle = idle_value;
    m_idle = idle_value;
    #3 compare_outputs();
  endtask

  function automatic bit event_seen(input int kind);
    case (kind)
      EV_OWED: return backlog_count != '0;
      EV_PALL: return sdram.cmd == sdram_refresh_pkg::CMD_PRECHARGE;
      EV_REF:  return sdram.cmd == sdram_refresh_pkg::CMD_REFRESH;
      EV_DONE: return refresh_done;
      EV_IDLE: return !refresh_busy;
      default: return backlog_count == '0 && !refresh_busy;
    endcase
  endfunction

  task automatic run_until(input int kind, input string what, input logic idle_value,
                           input int limit, output int at_cycle);
    int waited;
    bit hit;
    waited   = 0;
    hit      = 1'b0;
    at_cycle = -1;
    while (!hit && waited < limit) begin
      run_cycle(idle_value);
      waited++;
      hit = event_seen(kind);
    end
    if (hit) begin
      at_cycle = cyc;
    end else begin
      errors++;
      $display("Gave up waiting for %s after %0d cycles", what, limit);
    end
  endtask

  // Host lets go until nothing is owed and the FSM is idle
  task automatic drain_backlog();
    int owed;
    int ticks_at;
    int lost_at;
    int done_at;
    int at_end;
    owed     = m_count;  // Includes a sequence already running
    ticks_at = m_ticks;
    lost_at  = m_lost;
    done_at  = done_seen;
    run_until(EV_DRAINED, "backlog drain", 1'b1, DRAIN_LEN, at_end);
    expect_number("Refreshes done in drain", owed + (m_ticks - ticks_at) - (m_lost - lost_at),
                  done_seen - done_at);
    check_count("backlog_count", '0, backlog_count);
    check_flag("refresh_busy", 1'b0, refresh_busy);
  endtask

  task automatic finish_test(input int number, input string title);
    if (errors == test_errors_at) begin
      tests_passed++;
      $display("Test %0d %s: PASS", number, title);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL, %0d errors", number, title, errors - test_errors_at);
    end
    test_errors_at = errors;
  endtask

  initial begin
    int at_pend;
    int at_pall;
    int at_ref;
    int at_done;
    int at_idle;
    int owed;
    int ticks_at;
    int cmds_at;
    int spent;
    int stretch;
    logic level;
    logic [sdram_refresh_pkg::BACKLOG_W-1:0] exp_count;
    host_idle = 1'b0;
    errors = 0;
    test_errors_at = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(SEED));
    @(negedge reset);
    cyc = 1;  // Model starts in reset state
    m_active = 1'b0;
    m_phase = 0;
    m_count = '0;
    m_overflow = 1'b0;
    m_idle = 1'b0;
    m_ticks = 0;
    m_lost = 0;
    m_done = 0;
    pall_seen = 0;
    ref_seen = 0;
    done_seen = 0;
    #3 compare_outputs();

    // 1: quiet bus before the first tick
    while (cyc < INTERVAL - 1) run_cycle(1'b1);
    check_bus("sdram", idle_bus(), sdram);
    finish_test(1, "reset and idle bus");

    // 2: first refresh with the host idle
    run_until(EV_OWED, "first owed refresh", 1'b1, 2 * INTERVAL, at_pend);
    run_until(EV_PALL, "PRECHARGE", 1'b1, SEQ_LEN, at_pall);
    run_until(EV_REF, "REFRESH", 1'b1, SEQ_LEN, at_ref);
    run_until(EV_DONE, "refresh_done", 1'b1, SEQ_LEN, at_done);
    run_until(EV_IDLE, "busy to fall", 1'b1, SEQ_LEN, at_idle);
    expect_number("Cycles from pending to PRECHARGE", 1, at_pall - at_pend);
    expect_number("Cycles from PRECHARGE to REFRESH", REF_AT, at_ref - at_pall);
    expect_number("Cycles from REFRESH to done", sdram_refresh_pkg::T_RC + 1, at_done - at_ref);
    expect_number("Cycles from done to idle", 1, at_idle - at_done);
    finish_test(2, "single refresh timing");

    // 3: host busy, refreshes pile up
    owed = $urandom_range(MAX_OWED - 1, 1);
    ticks_at = m_ticks;
    cmds_at = pall_seen + ref_seen;
    repeat (owed * INTERVAL) run_cycle(1'b0);
    exp_count = m_ticks - ticks_at;
    check_count("backlog_count", exp_count, backlog_count);
    expect_number("Commands issued while host busy", 0, pall_seen + ref_seen - cmds_at);
    finish_test(3, "backlog accumulation");

    // 4: back-to-back drain
    drain_backlog();
    finish_test(4, "backlog drain");

    // 5: saturation and sticky overflow
    repeat ((MAX_OWED + 2) * INTERVAL) run_cycle(1'b0);
    exp_count = MAX_OWED;
    check_count("backlog_count", exp_count, backlog_count);
    check_flag("backlog_overflow", 1'b1, backlog_overflow);
    drain_backlog();
    check_flag("backlog_overflow", 1'b1, backlog_overflow);
    finish_test(5, "saturation and overflow");

    // 6: random stretches, short and long against the interval
    spent = 0;
    while (spent < RANDOM_CYCLES) begin
      level = $urandom_range(1, 0);
      if ($urandom_range(1, 0) != 0) stretch = $urandom_range(INTERVAL - 1, 1);
      else stretch = $urandom_range(3 * INTERVAL, INTERVAL + 1);
      repeat (stretch) run_cycle(level);
      spent += stretch;
    end
    drain_backlog();
    expect_number("PRECHARGE commands in the run", m_done, pall_seen);
    expect_number("REFRESH commands in the run", m_done, ref_seen);
    expect_number("Done pulses in the run", m_done, done_seen);
    finish_test(6, "random host activity");

    $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((RUN_CYCLES + MARGIN_CYCLES + 8) * CLK_PERIOD_NS);
    $display("Timeout: run did not end within %0d cycles", RUN_CYCLES + MARGIN_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
logic/sdram_refresh_pkg.sv
logic/refresh_timer.sv
logic/refresh_backlog.sv
logic/refresh_sequencer.sv
logic/sdram_refresh_top.sv
bench/tb_clock_gen.sv
bench/tb_sdram_refresh.sv

/* Bender.yml */
package:
  name: sdram_refresh

sources:
  - logic/sdram_refresh_pkg.sv
  - logic/refresh_timer.sv
  - logic/refresh_backlog.sv
  - logic/refresh_sequencer.sv
  - logic/sdram_refresh_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_sdram_refresh.sv
